// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - logic

sources:
  - files:
      - logic/decode_pkg.sv
      - logic/int_decoder.sv
      - logic/fp_decoder.sv
      - logic/decode_stage.sv
      - logic/decode_top.sv
  - target: simulation
    files:
      - bench/decode_tb.sv

// ==== bench/decode_tb.sv ====
`timescale 1ns/10ps

module decode_tb;
  import decode_pkg::*;

  localparam int MAX_LINES = 64;
  localparam logic [31:0] LFSR_SEED = 32'he473_0c86;

  // Expected decoder-side fields of one slot.
  typedef struct packed {
    logic  valid;
    logic  exception;
    ctrl_t ctrl;
    imm_t  imm;
    unit_t unit;
    op_t   op;
    fmt_t  fmt;
    rm_t   rm;
  } slot_exp_t;

  logic      clock;
  logic      reset;
  logic      fetch_ready;
  word_t     fetch_pc;
  packet_t   fetch_data;
  logic      halt, trap, mret, pred_miss, fence_exec, wb_clear;
  logic      q_valid0, q_exception0, q_valid1, q_exception1;
  word_t     q_pc0, q_npc0, q_instr0, q_pc1, q_npc1, q_instr1;
  reg_addr_t q_rd0, q_rs1_0, q_rs2_0, q_rs3_0;
  reg_addr_t q_rd1, q_rs1_1, q_rs2_1, q_rs3_1;
  ctrl_t     q_ctrl0, q_ctrl1;
  imm_t      q_imm0, q_imm1;
  unit_t     q_unit0, q_unit1;
  op_t       q_op0, q_op1;
  fmt_t      q_fmt0, q_fmt1;
  rm_t       q_rm0, q_rm1;

  logic        in_ready [MAX_LINES];
  word_t       in_pc [MAX_LINES];
  packet_t     in_data [MAX_LINES];
  logic [5:0]  in_kill [MAX_LINES]; // Halt, then the five flush sources.
  slot_exp_t   exp0 [MAX_LINES];
  slot_exp_t   exp1 [MAX_LINES];
  int          num_lines;
  bit          loaded;
  logic [31:0] lfsr;

  decode_top dut (.*);

  initial clock = 1'b0;
  always #20 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_imm(input string name, input imm_t exp, input imm_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_unit(input string name, input unit_t exp, input unit_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_op(input string name, input op_t exp, input op_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_fmt(input string name, input fmt_t exp, input fmt_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_rm(input string name, input rm_t exp, input rm_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
  endfunction

  // Drive delay of 1 to 5 ns from three LFSR bits.
  task automatic draw_delay(output int d);
    logic [2:0] bits;
    for (int b = 0; b < 3; b++) begin
      lfsr = lfsr_next(lfsr);
      bits[b] = lfsr[0];
    end
    d = 1 + int'(bits) % 5;
  endtask

  task automatic load_tests();
    int        fd;
    int        code;
    string     text;
    logic      rdy, hlt, trp, mrt, mis, fen, wbc;
    word_t     pc;
    packet_t   data;
    logic      v0, x0, v1, x1;
    ctrl_t     c0, c1;
    imm_t      i0, i1;
    unit_t     u0, u1;
    op_t       o0, o1;
    fmt_t      f0, f1;
    rm_t       m0, m1;
    fd = $fopen("bench/decode_tests.txt", "r");
    if (fd == 0)
      abort_run("Could not open bench/decode_tests.txt.");
    num_lines = 0;
    while (!$feof(fd)) begin
      text = "";
      code = $fgets(text, fd);
      if (code > 0 && text.len() > 1 && text[0] != "#") begin
        if (num_lines == MAX_LINES)
          abort_run("Test file holds more lines than the table can take.");
        code = $sscanf(text,
          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          rdy, pc, data, hlt, trp, mrt, mis, fen, wbc,
          v0, x0, c0, i0, u0, o0, f0, m0, v1, x1, c1, i1, u1, o1, f1, m1);
        if (code != 25)
          abort_run($sformatf("Could not parse test line: %s", text));
        in_ready[num_lines] = rdy;
        in_pc[num_lines] = pc;
        in_data[num_lines] = data;
        in_kill[num_lines] = {hlt, trp, mrt, mis, fen, wbc};
        exp0[num_lines] = {v0, x0, c0, i0, u0, o0, f0, m0};
        exp1[num_lines] = {v1, x1, c1, i1, u1, o1, f1, m1};
        num_lines++;
      end
    end
    $fclose(fd);
    if (num_lines == 0)
      abort_run("Test file holds no test lines.");
  endtask

  task automatic apply_line(input int i);
    fetch_ready = in_ready[i];
    fetch_pc = in_pc[i];
    fetch_data = in_data[i];
    {halt, trap, mret, pred_miss, fence_exec, wb_clear} = in_kill[i];
  endtask

  // Pc, instruction and register fields follow from the slot's inputs.
  task automatic check_slot(input string sfx, input string at, input logic ready,
                            input logic kill, input word_t pc_in, input word_t word_in,
                            input slot_exp_t e, input logic valid, input logic exception,
                            input word_t pc, input word_t npc, input word_t instr,
                            input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                            input reg_addr_t rs3, input ctrl_t ctrl, input imm_t imm,
                            input unit_t unit, input op_t op, input fmt_t fmt, input rm_t rm);
    word_t pc_e;
    word_t npc_e;
    word_t word_e;
    pc_e = ready ? pc_in : '1;
    npc_e = pc_e + 32'd4;
    word_e = ready ? word_in : '0;
    if (kill) begin
      pc_e = '0;
      npc_e = '0;
      word_e = '0;
    end
    check_bit({"q_valid", sfx, at}, e.valid, valid);
    check_bit({"q_exception", sfx, at}, e.exception, exception);
    check_word({"q_pc", sfx, at}, pc_e, pc);
    check_word({"q_npc", sfx, at}, npc_e, npc);
    check_word({"q_instr", sfx, at}, word_e, instr);
    check_reg({"q_rd", sfx, at}, word_e[11:7], rd);
    check_reg({"q_rs1_", sfx, at}, word_e[19:15], rs1);
    check_reg({"q_rs2_", sfx, at}, word_e[24:20], rs2);
    check_reg({"q_rs3_", sfx, at}, word_e[31:27], rs3);
    check_ctrl({"q_ctrl", sfx, at}, e.ctrl, ctrl);
    check_imm({"q_imm", sfx, at}, e.imm, imm);
    check_unit({"q_unit", sfx, at}, e.unit, unit);
    check_op({"q_op", sfx, at}, e.op, op);
    check_fmt({"q_fmt", sfx, at}, e.fmt, fmt);
    check_rm({"q_rm", sfx, at}, e.rm, rm);
  endtask

  task automatic check_outputs(input string at, input logic ready, input logic kill,
                               input word_t pc, input packet_t data,
                               input slot_exp_t e0, input slot_exp_t e1);
    check_slot("0", at, ready, kill, pc, data[31:0], e0, q_valid0, q_exception0,
               q_pc0, q_npc0, q_instr0, q_rd0, q_rs1_0, q_rs2_0, q_rs3_0,
               q_ctrl0, q_imm0, q_unit0, q_op0, q_fmt0, q_rm0);
    check_slot("1", at, ready, kill, pc + 32'd4, data[63:32], e1, q_valid1, q_exception1,
               q_pc1, q_npc1, q_instr1, q_rd1, q_rs1_1, q_rs2_1, q_rs3_1,
               q_ctrl1, q_imm1, q_unit1, q_op1, q_fmt1, q_rm1);
  endtask

  initial begin
    wait (loaded);
    #(num_lines * 40 + 2000);
    abort_run("Watchdog expired before the test table finished.");
  end

  initial begin
    int d;
    reset = 1'b0;
    fetch_ready = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    {halt, trap, mret, pred_miss, fence_exec, wb_clear} = '0;
    lfsr = LFSR_SEED;
    loaded = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (4) begin
      @(posedge clock);
      #2;
      check_outputs(" during reset", 1'b0, 1'b1, '0, '0, '0, '0); // All zero.
    end
    reset = 1'b1;
    apply_line(0);
    for (int i = 1; i <= num_lines; i++) begin
      @(posedge clock);
      draw_delay(d);
      #(d);
      check_outputs($sformatf(" at test %0d", i - 1), in_ready[i - 1], |in_kill[i - 1],
                    in_pc[i - 1], in_data[i - 1], exp0[i - 1], exp1[i - 1]);
      if (i < num_lines)
        apply_line(i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== bench/decode_tests.txt ====
# ready pc packet halt trap mret pred_miss fence_exec wb_clear, then for slot 0 and slot 1:
# valid exception ctrl imm unit op fmt rm, the registered result one cycle later (all hex)
1 00001000 005201B3FFB10093 1 0 0 0 0 0  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0
1 00001000 005201B3FFB10093 0 0 0 0 0 0  1 0 0003 FFFFFFFB 1 0 0 0  1 0 0007 00000000 1 0 0 0
1 00001008 4035549340838333 0 0 0 0 0 0  1 0 0007 00000000 1 1 0 0  1 0 0003 00000403 1 b 0 0
1 00001010 FFFFF617123455B7 0 0 0 0 0 0  1 0 1001 12345000 1 0 0 0  1 0 2001 FFFFF000 1 0 0 0
1 00001018 00008067008000EF 0 0 0 0 0 0  1 0 0401 00000008 2 0 0 0  1 0 0803 00000000 2 0 0 0
1 00001020 0041E863FE208EE3 0 0 0 0 0 0  1 0 0206 FFFFFFFC 2 0 0 0  1 0 0206 00000010 2 c 0 0
1 00001028 FE742C2300C32283 0 0 0 0 0 0  1 0 0083 0000000C 3 4 0 0  1 0 0106 FFFFFFF8 3 4 0 0
1 00001030 023100B300154483 0 0 0 0 0 0  1 0 0083 00000001 3 8 0 0  1 0 0007 00000000 4 0 0 0
1 00001038 300110F30262D233 0 0 0 0 0 0  1 0 0007 00000000 5 a 0 0  1 0 8003 00000300 7 2 0 0
1 00001040 000000730FF0000F 0 0 0 0 0 0  1 0 4000 00000000 7 0 0 0  1 0 8000 00000000 7 0 0 0
1 00001048 0081208730200073 0 0 0 0 0 0  1 0 8000 00000302 7 0 0 0  1 0 008A 00000008 3 4 0 0
1 00001050 003170D300322227 0 0 0 0 0 0  1 0 0122 00000004 3 4 0 0  1 0 0038 00000000 6 0 0 7
1 00001058 109423D308629253 0 0 0 0 0 0  1 0 0038 00000000 6 1 0 1  1 0 0038 00000000 6 2 0 2
1 00001060 E00302D3203100C3 0 0 0 0 0 0  1 0 0078 00000000 6 3 0 0  1 0 0011 00000000 6 4 0 0
1 00001068 FFFFFFFFF00403D3 0 0 0 0 0 0  1 0 000A 00000000 6 5 0 0  1 1 0000 00000000 0 0 0 0
1 00001070 003150D3023170D3 0 0 0 0 0 0  1 1 0000 00000000 0 0 0 0  1 1 0000 00000000 0 0 0 0
1 00001078 FFB1009340001033 0 0 0 0 0 0  1 1 0000 00000000 0 0 0 0  1 0 0003 FFFFFFFB 1 0 0 0
0 00002000 005201B3FFB10093 0 0 0 0 0 0  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0
1 00001080 005201B3FFB10093 1 0 0 0 0 0  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0
1 00001080 005201B3FFB10093 0 1 0 0 0 0  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0
1 00001080 005201B3FFB10093 0 0 1 0 0 0  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0
1 00001080 005201B3FFB10093 0 0 0 1 0 0  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0
1 00001080 005201B3FFB10093 0 0 0 0 1 0  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0
1 00001080 005201B3FFB10093 0 0 0 0 0 1  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0
1 FFFFFFF8 203100C300C32283 0 0 0 0 0 0  1 0 0083 0000000C 3 4 0 0  1 0 0078 00000000 6 3 0 0
0 00000000 0000000000000000 0 0 0 0 0 0  0 0 0000 00000000 0 0 0 0  0 0 0000 00000000 0 0 0 0

// ==== filelist.f ====
+incdir+logic
logic/decode_pkg.sv
logic/int_decoder.sv
logic/fp_decoder.sv
logic/decode_stage.sv
logic/decode_top.sv
bench/decode_tb.sv

// ==== logic/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define XLEN 32
`define PACKET_W 64
`define REG_ADDR_W 5
`define CTRL_W 16
`define OP_W 4

// Control vector bit positions.
`define CTRL_WREN 0
`define CTRL_RDEN1 1
`define CTRL_RDEN2 2
`define CTRL_FWREN 3
`define CTRL_FRDEN1 4
`define CTRL_FRDEN2 5
`define CTRL_FRDEN3 6
`define CTRL_LOAD 7
`define CTRL_STORE 8
`define CTRL_BRANCH 9
`define CTRL_JAL 10
`define CTRL_JALR 11
`define CTRL_LUI 12
`define CTRL_AUIPC 13
`define CTRL_FENCE 14
`define CTRL_SYSTEM 15

`define UNIT_NONE 3'd0
`define UNIT_ALU 3'd1
`define UNIT_BCU 3'd2 // Branches and jumps.
`define UNIT_LSU 3'd3
`define UNIT_MUL 3'd4
`define UNIT_DIV 3'd5
`define UNIT_FPU 3'd6
`define UNIT_SYS 3'd7 // Fence, CSR and privileged ops.

// FPU operation index.
`define FOP_ADD 4'd0
`define FOP_SUB 4'd1
`define FOP_MUL 4'd2
`define FOP_MADD 4'd3
`define FOP_MVXW 4'd4
`define FOP_MVWX 4'd5

`define FMT_S 2'b00 // Single precision.

`endif

// ==== logic/decode_pkg.sv ====
`include "decode_defines.svh"

package decode_pkg;

  // Pc or instruction word.
  typedef logic [`XLEN-1:0] word_t;

  // Two instructions from fetch with slot 0 in the low half.
  typedef logic [`PACKET_W-1:0] packet_t;

  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`XLEN-1:0] imm_t; // Sign-extended.

  typedef logic [`CTRL_W-1:0] ctrl_t;

  typedef logic [2:0] unit_t;

  // Funct3 with funct7 bit 5 below it, or the FPU op index.
  typedef logic [`OP_W-1:0] op_t;

  typedef logic [1:0] fmt_t;

  typedef logic [2:0] rm_t;

endpackage

// ==== logic/decode_stage.sv ====
`timescale 1ns/10ps
`include "decode_defines.svh"

module decode_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fetch_ready,
  input  decode_pkg::word_t     fetch_pc,
  input  decode_pkg::packet_t   fetch_data,
  input  logic                  halt, trap, mret, pred_miss, fence_exec, wb_clear,
  output decode_pkg::word_t     dec0_instr, dec1_instr,
  input  logic                  int0_recognized, int1_recognized,
  input  logic                  fp0_recognized, fp1_recognized,
  input  decode_pkg::ctrl_t     int0_ctrl, int1_ctrl, fp0_ctrl, fp1_ctrl,
  input  decode_pkg::imm_t      int0_imm, int1_imm, fp0_imm, fp1_imm,
  input  decode_pkg::unit_t     int0_unit, int1_unit, fp0_unit, fp1_unit,
  input  decode_pkg::op_t       int0_op, int1_op, fp0_op, fp1_op,
  input  decode_pkg::fmt_t      fp0_fmt, fp1_fmt,
  input  decode_pkg::rm_t       fp0_rm, fp1_rm,
  output logic                  y_valid0, y_exception0, y_valid1, y_exception1,
  output decode_pkg::word_t     y_pc0, y_npc0, y_instr0, y_pc1, y_npc1, y_instr1,
  output decode_pkg::reg_addr_t y_rd0, y_rs1_0, y_rs2_0, y_rs3_0,
  output decode_pkg::reg_addr_t y_rd1, y_rs1_1, y_rs2_1, y_rs3_1,
  output decode_pkg::ctrl_t     y_ctrl0, y_ctrl1,
  output decode_pkg::imm_t      y_imm0, y_imm1,
  output decode_pkg::unit_t     y_unit0, y_unit1,
  output decode_pkg::op_t       y_op0, y_op1,
  output decode_pkg::fmt_t      y_fmt0, y_fmt1,
  output decode_pkg::rm_t       y_rm0, y_rm1,
  output logic                  q_valid0, q_exception0, q_valid1, q_exception1,
  output decode_pkg::word_t     q_pc0, q_npc0, q_instr0, q_pc1, q_npc1, q_instr1,
  output decode_pkg::reg_addr_t q_rd0, q_rs1_0, q_rs2_0, q_rs3_0,
  output decode_pkg::reg_addr_t q_rd1, q_rs1_1, q_rs2_1, q_rs3_1,
  output decode_pkg::ctrl_t     q_ctrl0, q_ctrl1,
  output decode_pkg::imm_t      q_imm0, q_imm1,
  output decode_pkg::unit_t     q_unit0, q_unit1,
  output decode_pkg::op_t       q_op0, q_op1,
  output decode_pkg::fmt_t      q_fmt0, q_fmt1,
  output decode_pkg::rm_t       q_rm0, q_rm1
);
  import decode_pkg::*;

  // Bits per slot.
  localparam int SLOT_W = 4 * `XLEN + 4 * `REG_ADDR_W + `CTRL_W + `OP_W + 10;

  logic                flush;
  logic                kill;
  logic [2*SLOT_W-1:0] y_bus;
  logic [2*SLOT_W-1:0] q_bus;

  assign flush = trap | mret | pred_miss | fence_exec | wb_clear;
  assign kill = halt | flush;

  // Idle slots send a zero word to the decoders.
  assign dec0_instr = fetch_ready ? fetch_data[31:0] : '0;
  assign dec1_instr = fetch_ready ? fetch_data[63:32] : '0;

  always_comb begin
    y_valid0 = fetch_ready;
    y_pc0 = fetch_ready ? fetch_pc : '1;
    y_npc0 = y_pc0 + 32'd4;
    y_instr0 = dec0_instr;
    y_rd0 = dec0_instr[11:7];
    y_rs1_0 = dec0_instr[19:15];
    y_rs2_0 = dec0_instr[24:20];
    y_rs3_0 = dec0_instr[31:27];
    if (fp0_recognized) begin // FP result wins.
      y_ctrl0 = fp0_ctrl;
      y_imm0 = fp0_imm;
      y_unit0 = fp0_unit;
      y_op0 = fp0_op;
      y_fmt0 = fp0_fmt;
      y_rm0 = fp0_rm;
    end else begin
      y_ctrl0 = int0_ctrl;
      y_imm0 = int0_imm;
      y_unit0 = int0_unit;
      y_op0 = int0_op;
      y_fmt0 = '0;
      y_rm0 = '0;
    end
    y_exception0 = fetch_ready & ~(int0_recognized | fp0_recognized);
    if (!(int0_recognized | fp0_recognized)) begin
      y_ctrl0 = '0;
      y_unit0 = `UNIT_NONE;
    end
    if (kill) begin
      {y_valid0, y_exception0, y_pc0, y_npc0, y_instr0, y_rd0, y_rs1_0, y_rs2_0, y_rs3_0,
       y_ctrl0, y_imm0, y_unit0, y_op0, y_fmt0, y_rm0} = {SLOT_W{1'b0}};
    end
  end

  always_comb begin
    y_valid1 = fetch_ready;
    y_pc1 = fetch_ready ? fetch_pc + 32'd4 : '1; // Upper half of the packet.
    y_npc1 = y_pc1 + 32'd4;
    y_instr1 = dec1_instr;
    y_rd1 = dec1_instr[11:7];
    y_rs1_1 = dec1_instr[19:15];
    y_rs2_1 = dec1_instr[24:20];
    y_rs3_1 = dec1_instr[31:27];
    if (fp1_recognized) begin
      y_ctrl1 = fp1_ctrl;
      y_imm1 = fp1_imm;
      y_unit1 = fp1_unit;
      y_op1 = fp1_op;
      y_fmt1 = fp1_fmt;
      y_rm1 = fp1_rm;
    end else begin
      y_ctrl1 = int1_ctrl;
      y_imm1 = int1_imm;
      y_unit1 = int1_unit;
      y_op1 = int1_op;
      y_fmt1 = '0;
      y_rm1 = '0;
    end
    y_exception1 = fetch_ready & ~(int1_recognized | fp1_recognized);
    if (!(int1_recognized | fp1_recognized)) begin
      y_ctrl1 = '0;
      y_unit1 = `UNIT_NONE;
    end
    if (kill) begin
      {y_valid1, y_exception1, y_pc1, y_npc1, y_instr1, y_rd1, y_rs1_1, y_rs2_1, y_rs3_1,
       y_ctrl1, y_imm1, y_unit1, y_op1, y_fmt1, y_rm1} = {SLOT_W{1'b0}};
    end
  end

  assign y_bus = {y_valid1, y_exception1, y_pc1, y_npc1, y_instr1,
                  y_rd1, y_rs1_1, y_rs2_1, y_rs3_1,
                  y_ctrl1, y_imm1, y_unit1, y_op1, y_fmt1, y_rm1,
                  y_valid0, y_exception0, y_pc0, y_npc0, y_instr0,
                  y_rd0, y_rs1_0, y_rs2_0, y_rs3_0,
                  y_ctrl0, y_imm0, y_unit0, y_op0, y_fmt0, y_rm0};

  always_ff @(posedge clock) begin
    if (!reset) begin
      q_bus <= '0;
    end else begin
      q_bus <= y_bus;
    end
  end

  assign {q_valid1, q_exception1, q_pc1, q_npc1, q_instr1,
          q_rd1, q_rs1_1, q_rs2_1, q_rs3_1,
          q_ctrl1, q_imm1, q_unit1, q_op1, q_fmt1, q_rm1,
          q_valid0, q_exception0, q_pc0, q_npc0, q_instr0,
          q_rd0, q_rs1_0, q_rs2_0, q_rs3_0,
          q_ctrl0, q_imm0, q_unit0, q_op0, q_fmt0, q_rm0} = q_bus;

endmodule

// ==== logic/decode_top.sv ====
`timescale 1ns/10ps

module decode_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fetch_ready,
  input  decode_pkg::word_t     fetch_pc,
  input  decode_pkg::packet_t   fetch_data,
  input  logic                  halt, trap, mret, pred_miss, fence_exec, wb_clear,
  output logic                  q_valid0, q_exception0, q_valid1, q_exception1,
  output decode_pkg::word_t     q_pc0, q_npc0, q_instr0, q_pc1, q_npc1, q_instr1,
  output decode_pkg::reg_addr_t q_rd0, q_rs1_0, q_rs2_0, q_rs3_0,
  output decode_pkg::reg_addr_t q_rd1, q_rs1_1, q_rs2_1, q_rs3_1,
  output decode_pkg::ctrl_t     q_ctrl0, q_ctrl1,
  output decode_pkg::imm_t      q_imm0, q_imm1,
  output decode_pkg::unit_t     q_unit0, q_unit1,
  output decode_pkg::op_t       q_op0, q_op1,
  output decode_pkg::fmt_t      q_fmt0, q_fmt1,
  output decode_pkg::rm_t       q_rm0, q_rm1
);
  import decode_pkg::*;

  word_t dec0_instr, dec1_instr;
  logic  int0_recognized, int1_recognized, fp0_recognized, fp1_recognized;
  ctrl_t int0_ctrl, int1_ctrl, fp0_ctrl, fp1_ctrl;
  imm_t  int0_imm, int1_imm, fp0_imm, fp1_imm;
  unit_t int0_unit, int1_unit, fp0_unit, fp1_unit;
  op_t   int0_op, int1_op, fp0_op, fp1_op;
  fmt_t  fp0_fmt, fp1_fmt;
  rm_t   fp0_rm, fp1_rm;

  // Only the registered view leaves the top.
  decode_stage stage (
    .*,
    .y_valid0(), .y_exception0(), .y_pc0(), .y_npc0(), .y_instr0(),
    .y_rd0(), .y_rs1_0(), .y_rs2_0(), .y_rs3_0(), .y_ctrl0(),
    .y_imm0(), .y_unit0(), .y_op0(), .y_fmt0(), .y_rm0(),
    .y_valid1(), .y_exception1(), .y_pc1(), .y_npc1(), .y_instr1(),
    .y_rd1(), .y_rs1_1(), .y_rs2_1(), .y_rs3_1(), .y_ctrl1(),
    .y_imm1(), .y_unit1(), .y_op1(), .y_fmt1(), .y_rm1()
  );

  int_decoder int_dec0 (
    .instr      (dec0_instr),
    .recognized (int0_recognized),
    .ctrl       (int0_ctrl),
    .imm        (int0_imm),
    .unit       (int0_unit),
    .op         (int0_op)
  );

  int_decoder int_dec1 (
    .instr      (dec1_instr),
    .recognized (int1_recognized),
    .ctrl       (int1_ctrl),
    .imm        (int1_imm),
    .unit       (int1_unit),
    .op         (int1_op)
  );

  fp_decoder fp_dec0 (
    .instr      (dec0_instr),
    .recognized (fp0_recognized),
    .ctrl       (fp0_ctrl),
    .imm        (fp0_imm),
    .unit       (fp0_unit),
    .op         (fp0_op),
    .fmt        (fp0_fmt),
    .rm         (fp0_rm)
  );

  fp_decoder fp_dec1 (
    .instr      (dec1_instr),
    .recognized (fp1_recognized),
    .ctrl       (fp1_ctrl),
    .imm        (fp1_imm),
    .unit       (fp1_unit),
    .op         (fp1_op),
    .fmt        (fp1_fmt),
    .rm         (fp1_rm)
  );

endmodule

// ==== logic/fp_decoder.sv ====
`timescale 1ns/10ps
`include "decode_defines.svh"

module fp_decoder (
  input  decode_pkg::word_t instr,
  output logic              recognized,
  output decode_pkg::ctrl_t ctrl,
  output decode_pkg::imm_t  imm,
  output decode_pkg::unit_t unit,
  output decode_pkg::op_t   op,
  output decode_pkg::fmt_t  fmt,
  output decode_pkg::rm_t   rm
);
  import decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  logic       single;
  logic       rm_ok;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct5 = instr[31:27];
  assign single = instr[26:25] == `FMT_S;
  assign rm_ok = funct3 != 3'b101 && funct3 != 3'b110; // Reserved rounding modes.

  always_comb begin
    recognized = 1'b0;
    ctrl = '0;
    imm = '0;
    unit = `UNIT_NONE;
    op = '0;
    fmt = '0;
    rm = '0;
    case (opcode)
      7'b0000111: begin
        if (funct3 == 3'b010) begin // Flw.
          recognized = 1'b1;
          ctrl[`CTRL_FWREN] = 1'b1;
          ctrl[`CTRL_RDEN1] = 1'b1;
          ctrl[`CTRL_LOAD] = 1'b1;
          imm = {{20{instr[31]}}, instr[31:20]};
          unit = `UNIT_LSU;
          op = {funct3, 1'b0};
        end
      end
      7'b0100111: begin
        if (funct3 == 3'b010) begin // Fsw.
          recognized = 1'b1;
          ctrl[`CTRL_RDEN1] = 1'b1;
          ctrl[`CTRL_FRDEN2] = 1'b1;
          ctrl[`CTRL_STORE] = 1'b1;
          imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
          unit = `UNIT_LSU;
          op = {funct3, 1'b0};
        end
      end
      7'b1000011: begin
        if (single && rm_ok) begin // Fmadd.s.
          recognized = 1'b1;
          ctrl[`CTRL_FWREN] = 1'b1;
          ctrl[`CTRL_FRDEN1] = 1'b1;
          ctrl[`CTRL_FRDEN2] = 1'b1;
          ctrl[`CTRL_FRDEN3] = 1'b1;
          unit = `UNIT_FPU;
          op = `FOP_MADD;
          fmt = instr[26:25];
          rm = funct3;
        end
      end
      7'b1010011: begin
        if (single) begin
          case (funct5)
            5'b00000, 5'b00001, 5'b00010: begin
              if (rm_ok) begin
                recognized = 1'b1;
                ctrl[`CTRL_FWREN] = 1'b1;
                ctrl[`CTRL_FRDEN1] = 1'b1;
                ctrl[`CTRL_FRDEN2] = 1'b1;
                unit = `UNIT_FPU;
                fmt = instr[26:25];
                rm = funct3;
                case (funct5[1:0])
                  2'b00: op = `FOP_ADD;
                  2'b01: op = `FOP_SUB;
                  default: op = `FOP_MUL;
                endcase
              end
            end
            5'b11100: begin
              if (instr[24:20] == 5'd0 && funct3 == 3'b000) begin
                recognized = 1'b1; // Fmv.x.w writes an integer register.
                ctrl[`CTRL_WREN] = 1'b1;
                ctrl[`CTRL_FRDEN1] = 1'b1;
                unit = `UNIT_FPU;
                op = `FOP_MVXW;
                fmt = instr[26:25];
              end
            end
            5'b11110: begin
              if (instr[24:20] == 5'd0 && funct3 == 3'b000) begin
                recognized = 1'b1;
                ctrl[`CTRL_FWREN] = 1'b1;
                ctrl[`CTRL_RDEN1] = 1'b1;
                unit = `UNIT_FPU;
                op = `FOP_MVWX;
                fmt = instr[26:25];
              end
            end
            default: begin
              recognized = 1'b0;
            end
          endcase
        end
      end
      default: begin
        recognized = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/int_decoder.sv ====
`timescale 1ns/10ps
`include "decode_defines.svh"

module int_decoder (
  input  decode_pkg::word_t instr,
  output logic              recognized,
  output decode_pkg::ctrl_t ctrl,
  output decode_pkg::imm_t  imm,
  output decode_pkg::unit_t unit,
  output decode_pkg::op_t   op
);
  import decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_t       imm_i;
  imm_t       imm_s;
  imm_t       imm_b;
  imm_t       imm_u;
  imm_t       imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    recognized = 1'b0;
    ctrl = '0;
    imm = '0;
    unit = `UNIT_NONE;
    op = '0;
    case (opcode)
      7'b0110111: begin // Lui.
        recognized = 1'b1;
        ctrl[`CTRL_WREN] = 1'b1;
        ctrl[`CTRL_LUI] = 1'b1;
        imm = imm_u;
        unit = `UNIT_ALU;
      end
      7'b0010111: begin // Auipc.
        recognized = 1'b1;
        ctrl[`CTRL_WREN] = 1'b1;
        ctrl[`CTRL_AUIPC] = 1'b1;
        imm = imm_u;
        unit = `UNIT_ALU;
      end
      7'b1101111: begin
        recognized = 1'b1;
        ctrl[`CTRL_WREN] = 1'b1;
        ctrl[`CTRL_JAL] = 1'b1;
        imm = imm_j;
        unit = `UNIT_BCU;
      end
      7'b1100111: begin
        if (funct3 == 3'b000) begin
          recognized = 1'b1;
          ctrl[`CTRL_WREN] = 1'b1;
          ctrl[`CTRL_RDEN1] = 1'b1;
          ctrl[`CTRL_JALR] = 1'b1;
          imm = imm_i;
          unit = `UNIT_BCU;
        end
      end
      7'b1100011: begin
        // Funct3 010 and 011 are unused.
        if (funct3[2:1] != 2'b01) begin
          recognized = 1'b1;
          ctrl[`CTRL_RDEN1] = 1'b1;
          ctrl[`CTRL_RDEN2] = 1'b1;
          ctrl[`CTRL_BRANCH] = 1'b1;
          imm = imm_b;
          unit = `UNIT_BCU;
          op = {funct3, 1'b0};
        end
      end
      7'b0000011: begin
        if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
          recognized = 1'b1;
          ctrl[`CTRL_WREN] = 1'b1;
          ctrl[`CTRL_RDEN1] = 1'b1;
          ctrl[`CTRL_LOAD] = 1'b1;
          imm = imm_i;
          unit = `UNIT_LSU;
          op = {funct3, 1'b0};
        end
      end
      7'b0100011: begin
        if (funct3[2] == 1'b0 && funct3 != 3'b011) begin
          recognized = 1'b1;
          ctrl[`CTRL_RDEN1] = 1'b1;
          ctrl[`CTRL_RDEN2] = 1'b1;
          ctrl[`CTRL_STORE] = 1'b1;
          imm = imm_s;
          unit = `UNIT_LSU;
          op = {funct3, 1'b0};
        end
      end
      7'b0010011: begin
        // Shift immediates restrict funct7.
        if ((funct3 != 3'b001 && funct3 != 3'b101) ||
            (funct3 == 3'b001 && funct7 == 7'b0000000) ||
            (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000))) begin
          recognized = 1'b1;
          ctrl[`CTRL_WREN] = 1'b1;
          ctrl[`CTRL_RDEN1] = 1'b1;
          imm = imm_i;
          unit = `UNIT_ALU;
          op = {funct3, funct3 == 3'b101 && instr[30]};
        end
      end
      7'b0110011: begin
        if (funct7 == 7'b0000000 || funct7 == 7'b0000001 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          recognized = 1'b1;
          ctrl[`CTRL_WREN] = 1'b1;
          ctrl[`CTRL_RDEN1] = 1'b1;
          ctrl[`CTRL_RDEN2] = 1'b1;
          op = {funct3, funct7[5]};
          if (funct7[0]) begin
            unit = funct3[2] ? `UNIT_DIV : `UNIT_MUL; // M extension.
          end else begin
            unit = `UNIT_ALU;
          end
        end
      end
      7'b0001111: begin
        if (funct3 == 3'b000) begin
          recognized = 1'b1;
          ctrl[`CTRL_FENCE] = 1'b1;
          unit = `UNIT_SYS;
        end
      end
      7'b1110011: begin
        if (funct3 == 3'b000) begin
          // Ecall, ebreak, mret and wfi are told apart by imm.
          if (instr == 32'h0000_0073 || instr == 32'h0010_0073 ||
              instr == 32'h3020_0073 || instr == 32'h1050_0073) begin
            recognized = 1'b1;
            ctrl[`CTRL_SYSTEM] = 1'b1;
            imm = imm_i;
            unit = `UNIT_SYS;
          end
        end else if (funct3 != 3'b100) begin
          recognized = 1'b1; // CSR access.
          ctrl[`CTRL_WREN] = 1'b1;
          ctrl[`CTRL_RDEN1] = ~funct3[2];
          ctrl[`CTRL_SYSTEM] = 1'b1;
          imm = imm_i;
          unit = `UNIT_SYS;
          op = {funct3, 1'b0};
        end
      end
      default: begin
        recognized = 1'b0;
      end
    endcase
  end

endmodule
